//--- Bender.yml
package:
  name: region

sources:
  - files:
      - hw/region_pkg.sv
      - hw/fifobram_if.sv
      - hw/bram.sv
      - hw/fifo.sv
      - hw/region.sv
      - hw/region_top.sv
  - target: test
    files:
      - test/region_properties.sv
      - test/region_tb.sv

//--- flist.f
hw/region_pkg.sv
hw/fifobram_if.sv
hw/bram.sv
hw/fifo.sv
hw/region.sv
hw/region_top.sv
test/region_properties.sv
test/region_tb.sv

//--- hw/bram.sv
`timescale 1ns/1ps

module bram #(
    parameter int WIDTH = region_pkg::DATA_WIDTH,
    parameter int LOG2_DEPTH = region_pkg::LOG2_DEPTH
) (
    input logic clk,
    fifobram_if.bram_side access
);

    logic [WIDTH-1:0] ram [1 << LOG2_DEPTH];

    always_ff @(posedge clk) begin
        if (access.we) begin
            ram[access.waddr] <= access.wdata;
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (access.re) begin
            access.rdata <= ram[access.raddr];
        end
        access.rvalid <= access.re;
    end

endmodule

//--- hw/fifo.sv
`timescale 1ns/1ps

module fifo #(
    parameter int WIDTH = region_pkg::DATA_WIDTH,
    parameter int LOG2_DEPTH = region_pkg::LOG2_DEPTH
) (
    input logic clk,
    input logic rst,
    fifobram_if.fifo_side access
);

    import region_pkg::*;

    localparam int FIFO_DEPTH = 1 << LOG2_DEPTH;

    logic [WIDTH-1:0]      buffer [FIFO_DEPTH];
    logic [LOG2_DEPTH-1:0] rd_ptr;
    logic [LOG2_DEPTH-1:0] wr_ptr;
    logic [LOG2_DEPTH:0]   occupancy;
    logic                  is_empty;
    logic                  is_full;
    logic                  push;
    logic                  pop;

    assign is_empty = occupancy == '0;
    assign is_full  = occupancy == (LOG2_DEPTH + 1)'(FIFO_DEPTH);

    // Push when full and pop when empty are dropped
    assign push = access.we && !is_full;
    assign pop  = access.re && !is_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            occupancy     <= '0;
            access.rvalid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            access.rvalid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wr_ptr] <= access.wdata;
        end
        if (pop) begin
            access.rdata <= buffer[rd_ptr];
        end
    end

    assign access.count      = occupancy;
    assign access.empty      = is_empty;
    assign access.almostfull = occupancy >= (LOG2_DEPTH + 1)'(FIFO_DEPTH - AF_MARGIN);

endmodule

//--- hw/fifobram_if.sv
`timescale 1ns/1ps

interface fifobram_if #(
    parameter int WIDTH = region_pkg::DATA_WIDTH,
    parameter int LOG2_DEPTH = region_pkg::LOG2_DEPTH
);

    // Write side
    logic                  we;
    logic [LOG2_DEPTH-1:0] waddr;
    logic [WIDTH-1:0]      wdata;

    // Read side
    logic                  re;
    logic [LOG2_DEPTH-1:0] raddr;
    logic                  rvalid;
    logic [WIDTH-1:0]      rdata;

    // FIFO status
    logic                  empty;
    logic                  almostfull;
    logic [LOG2_DEPTH:0]   count;

    modport region (
        output we, waddr, wdata, re, raddr,
        input  rvalid, rdata, empty, almostfull, count
    );

    modport bram_side (
        input  we, waddr, wdata, re, raddr,
        output rvalid, rdata
    );

    // FIFO ignores the addresses
    modport fifo_side (
        input  we, wdata, re,
        output rvalid, rdata, empty, almostfull, count
    );

endinterface

//--- hw/region.sv
`timescale 1ns/1ps

module region #(
    parameter int NUM_CHANNELS = region_pkg::NUM_CHANNELS
) (
    input  logic clk,
    input  logic rst,

    input  logic [NUM_CHANNELS-1:0]                               ch_re,
    input  region_pkg::region_sel_u [NUM_CHANNELS-1:0]            ch_rsel,
    input  logic [NUM_CHANNELS-1:0][region_pkg::LOG2_DEPTH-1:0]   ch_raddr,

    input  logic [NUM_CHANNELS-1:0]                               ch_we,
    input  region_pkg::region_sel_u [NUM_CHANNELS-1:0]            ch_wsel,
    input  logic [NUM_CHANNELS-1:0][region_pkg::LOG2_DEPTH-1:0]   ch_waddr,
    input  logic [NUM_CHANNELS-1:0][region_pkg::DATA_WIDTH-1:0]   ch_wdata,

    output logic [NUM_CHANNELS-1:0]                               ch_rvalid,
    output logic [NUM_CHANNELS-1:0][region_pkg::DATA_WIDTH-1:0]   ch_rdata,

    output logic                                                  empty,
    output logic                                                  almostfull,
    output logic [region_pkg::LOG2_DEPTH:0]                       count,

    fifobram_if.region mem,
    fifobram_if.region fq
);

    import region_pkg::*;

    logic [NUM_CHANNELS-1:0] rd_mem_req;
    logic [NUM_CHANNELS-1:0] rd_fifo_req;
    logic [NUM_CHANNELS-1:0] rd_mem_gnt;
    logic [NUM_CHANNELS-1:0] rd_fifo_gnt;
    logic [NUM_CHANNELS-1:0] rd_mem_gnt_q;
    logic [NUM_CHANNELS-1:0] rd_fifo_gnt_q;
    logic [NUM_CHANNELS-1:0] wr_mem_req;
    logic [NUM_CHANNELS-1:0] wr_fifo_req;
    logic [NUM_CHANNELS-1:0] wr_mem_gnt;
    logic [NUM_CHANNELS-1:0] wr_fifo_gnt;

    // Fixed priority, lowest index wins
    function automatic logic [NUM_CHANNELS-1:0] first_req(input logic [NUM_CHANNELS-1:0] req);
        logic [NUM_CHANNELS-1:0] gnt;
        gnt = '0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt    = '0;
                gnt[i] = 1'b1;
            end
        end
        return gnt;
    endfunction

    // ************************************************************
    //   Read path
    // ************************************************************
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            rd_mem_req[i]  = ch_re[i] && ch_rsel[i].code == RD_MEM;
            rd_fifo_req[i] = ch_re[i] && ch_rsel[i].code == RD_FIFO;
        end
    end

    assign rd_mem_gnt  = first_req(rd_mem_req);
    assign rd_fifo_gnt = first_req(rd_fifo_req);

    assign mem.re = |rd_mem_req;
    assign fq.re  = |rd_fifo_req;

    always_comb begin
        mem.raddr = '0;
        fq.raddr  = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (rd_mem_gnt[i]) begin
                mem.raddr = ch_raddr[i];
            end
            if (rd_fifo_gnt[i]) begin
                fq.raddr = ch_raddr[i];
            end
        end
    end

    // Remember who asked, storage answers one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_mem_gnt_q  <= '0;
            rd_fifo_gnt_q <= '0;
        end else begin
            rd_mem_gnt_q  <= rd_mem_gnt;
            rd_fifo_gnt_q <= rd_fifo_gnt;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            ch_rvalid[i] = (rd_mem_gnt_q[i] && mem.rvalid) || (rd_fifo_gnt_q[i] && fq.rvalid);
            if (rd_mem_gnt_q[i]) begin
                ch_rdata[i] = mem.rdata;
            end else if (rd_fifo_gnt_q[i]) begin
                ch_rdata[i] = fq.rdata;
            end else begin
                ch_rdata[i] = '0;
            end
        end
    end

    // ************************************************************
    //   Write path
    // ************************************************************
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            wr_mem_req[i]  = ch_we[i] && ch_wsel[i].mask.mem;
            wr_fifo_req[i] = ch_we[i] && ch_wsel[i].mask.fifo;
        end
    end

    assign wr_mem_gnt  = first_req(wr_mem_req);
    assign wr_fifo_gnt = first_req(wr_fifo_req);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem.we <= 1'b0;
            fq.we  <= 1'b0;
        end else begin
            mem.we <= |wr_mem_req;
            fq.we  <= |wr_fifo_req;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (wr_mem_gnt[i]) begin
                mem.waddr <= ch_waddr[i];
                mem.wdata <= ch_wdata[i];
            end
            if (wr_fifo_gnt[i]) begin
                fq.waddr <= ch_waddr[i];
                fq.wdata <= ch_wdata[i];
            end
        end
    end

    // FIFO status goes to every channel
    assign empty      = fq.empty;
    assign almostfull = fq.almostfull;
    assign count      = fq.count;

endmodule

//--- hw/region_pkg.sv
package region_pkg;

    localparam int DATA_WIDTH = 16;
    localparam int LOG2_DEPTH = 5;
    localparam int DEPTH = 1 << LOG2_DEPTH;
    localparam int NUM_CHANNELS = 2;

    // Almostfull threshold below DEPTH
    localparam int AF_MARGIN = 4;

    // Read select, one target per request
    typedef enum logic [1:0] {
        RD_NONE = 2'b00,
        RD_MEM  = 2'b01,
        RD_FIFO = 2'b10
    } rd_target_e;

    // Write select, any combination of targets
    typedef struct packed {
        logic fifo;
        logic mem;
    } wr_mask_t;

    // Same two bits, code on reads and mask on writes
    typedef union packed {
        rd_target_e code;
        wr_mask_t   mask;
    } region_sel_u;

endpackage

//--- hw/region_top.sv
`timescale 1ns/1ps

module region_top (
    input  logic clk,
    input  logic rst,

    input  logic [region_pkg::NUM_CHANNELS-1:0]                             ch_re,
    input  region_pkg::region_sel_u [region_pkg::NUM_CHANNELS-1:0]          ch_rsel,
    input  logic [region_pkg::NUM_CHANNELS-1:0][region_pkg::LOG2_DEPTH-1:0] ch_raddr,

    input  logic [region_pkg::NUM_CHANNELS-1:0]                             ch_we,
    input  region_pkg::region_sel_u [region_pkg::NUM_CHANNELS-1:0]          ch_wsel,
    input  logic [region_pkg::NUM_CHANNELS-1:0][region_pkg::LOG2_DEPTH-1:0] ch_waddr,
    input  logic [region_pkg::NUM_CHANNELS-1:0][region_pkg::DATA_WIDTH-1:0] ch_wdata,

    output logic [region_pkg::NUM_CHANNELS-1:0]                             ch_rvalid,
    output logic [region_pkg::NUM_CHANNELS-1:0][region_pkg::DATA_WIDTH-1:0] ch_rdata,

    output logic                                                            empty,
    output logic                                                            almostfull,
    output logic [region_pkg::LOG2_DEPTH:0]                                 count
);

    import region_pkg::*;

    // Storage ports
    fifobram_if #(
        .WIDTH      (DATA_WIDTH),
        .LOG2_DEPTH (LOG2_DEPTH)
    ) mem_if ();

    fifobram_if #(
        .WIDTH      (DATA_WIDTH),
        .LOG2_DEPTH (LOG2_DEPTH)
    ) fq_if ();

    bram #(
        .WIDTH      (DATA_WIDTH),
        .LOG2_DEPTH (LOG2_DEPTH)
    ) bram_inst (
        .clk    (clk),
        .access (mem_if.bram_side)
    );

    fifo #(
        .WIDTH      (DATA_WIDTH),
        .LOG2_DEPTH (LOG2_DEPTH)
    ) fifo_inst (
        .clk    (clk),
        .rst    (rst),
        .access (fq_if.fifo_side)
    );

    region #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) region_inst (
        .clk        (clk),
        .rst        (rst),
        .ch_re      (ch_re),
        .ch_rsel    (ch_rsel),
        .ch_raddr   (ch_raddr),
        .ch_we      (ch_we),
        .ch_wsel    (ch_wsel),
        .ch_waddr   (ch_waddr),
        .ch_wdata   (ch_wdata),
        .ch_rvalid  (ch_rvalid),
        .ch_rdata   (ch_rdata),
        .empty      (empty),
        .almostfull (almostfull),
        .count      (count),
        .mem        (mem_if.region),
        .fq         (fq_if.region)
    );

endmodule

//--- test/region_properties.sv
`timescale 1ns/1ps

module region_properties #(
    parameter int NUM_CHANNELS = region_pkg::NUM_CHANNELS
) (
    input logic                                       clk,
    input logic                                       rst,
    input logic [NUM_CHANNELS-1:0]                    ch_re,
    input region_pkg::region_sel_u [NUM_CHANNELS-1:0] ch_rsel,
    input logic [NUM_CHANNELS-1:0]                    ch_rvalid,
    input logic [region_pkg::LOG2_DEPTH:0]            count
);

    import region_pkg::*;

    logic [NUM_CHANNELS-1:0] mem_asked;
    logic [NUM_CHANNELS-1:0] fifo_asked;

    // Channels asking each target, before arbitration
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            mem_asked[i]  = ch_re[i] && ch_rsel[i].code == RD_MEM;
            fifo_asked[i] = ch_re[i] && ch_rsel[i].code == RD_FIFO;
        end
    end

    // One answer per target per cycle
    mem_single_reader: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ch_rvalid & $past(mem_asked)))
        else $error("more than one channel answered from the RAM");

    fifo_single_reader: assert property (@(posedge clk) disable iff (rst)
        $onehot0(ch_rvalid & $past(fifo_asked)))
        else $error("more than one channel answered from the FIFO");

    rvalid_needs_re: assert property (@(posedge clk) disable iff (rst)
        (ch_rvalid & ~$past(ch_re)) == '0)
        else $error("rvalid on a channel that issued no read");

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= DEPTH)
        else $error("FIFO count above depth");

    rvalid_low_after_reset: assert property (@(posedge clk)
        rst |=> ch_rvalid == '0)
        else $error("rvalid high in the cycle after reset");

endmodule

bind region region_properties #(
    .NUM_CHANNELS (NUM_CHANNELS)
) region_properties_inst (
    .clk       (clk),
    .rst       (rst),
    .ch_re     (ch_re),
    .ch_rsel   (ch_rsel),
    .ch_rvalid (ch_rvalid),
    .count     (count)
);

//--- test/region_tb.sv
`timescale 1ns/1ps

module region_tb;

    import region_pkg::*;

    localparam int MAX_CYCLES = 2000;
    localparam int WORDS_PER_CH = 8;
    localparam wr_mask_t MASK_MEM  = '{fifo: 1'b0, mem: 1'b1};
    localparam wr_mask_t MASK_FIFO = '{fifo: 1'b1, mem: 1'b0};
    localparam wr_mask_t MASK_BOTH = '{fifo: 1'b1, mem: 1'b1};

    logic                                    clk;
    logic                                    rst;
    logic [NUM_CHANNELS-1:0]                 ch_re;
    region_sel_u [NUM_CHANNELS-1:0]          ch_rsel;
    logic [NUM_CHANNELS-1:0][LOG2_DEPTH-1:0] ch_raddr;
    logic [NUM_CHANNELS-1:0]                 ch_we;
    region_sel_u [NUM_CHANNELS-1:0]          ch_wsel;
    logic [NUM_CHANNELS-1:0][LOG2_DEPTH-1:0] ch_waddr;
    logic [NUM_CHANNELS-1:0][DATA_WIDTH-1:0] ch_wdata;
    logic [NUM_CHANNELS-1:0]                 ch_rvalid;
    logic [NUM_CHANNELS-1:0][DATA_WIDTH-1:0] ch_rdata;
    logic                                    empty;
    logic                                    almostfull;
    logic [LOG2_DEPTH:0]                     count;

    logic [15:0]           lfsr_state = 16'd62;
    logic [DATA_WIDTH-1:0] mem_model [DEPTH];
    logic [DATA_WIDTH-1:0] fifo_model [$];
    int                    errors = 0;
    int                    cycles = 0;

    region_top region_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [DATA_WIDTH-1:0] random_bits(input int n);
        logic [DATA_WIDTH-1:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            r = {r[DATA_WIDTH-2:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // Ends two cycles after we, when the storage holds the word
    task automatic write_word(input int ch, input wr_mask_t mask,
                              input logic [LOG2_DEPTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data);
        ch_we[ch]        = 1'b1;
        ch_wsel[ch].mask = mask;
        ch_waddr[ch]     = addr;
        ch_wdata[ch]     = data;
        if (mask.mem) mem_model[addr] = data;
        if (mask.fifo && fifo_model.size() < DEPTH) fifo_model.push_back(data);
        @(negedge clk);
        ch_we[ch] = 1'b0;
        @(negedge clk);
    endtask

    task automatic read_word(input int ch, input rd_target_e code,
                             input logic [LOG2_DEPTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] exp);
        logic [NUM_CHANNELS-1:0] want;
        want     = '0;
        want[ch] = 1'b1;
        ch_re[ch]        = 1'b1;
        ch_rsel[ch].code = code;
        ch_raddr[ch]     = addr;
        @(negedge clk);
        ch_re[ch] = 1'b0;
        if (ch_rvalid !== want) begin
            report_error($sformatf("ch %0d rvalid %b, expected %b", ch, ch_rvalid, want));
        end else if (ch_rdata[ch] !== exp) begin
            report_error($sformatf("ch %0d read %h, expected %h", ch, ch_rdata[ch], exp));
        end
        @(negedge clk);
        if (ch_rvalid !== '0) report_error("rvalid high for more than one cycle");
    endtask

    // ************************************************************
    //   Directed tests
    // ************************************************************
    task automatic test_mem_rw();
        logic [LOG2_DEPTH-1:0] addrs [NUM_CHANNELS][WORDS_PER_CH];
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int i = 0; i < WORDS_PER_CH; i++) begin
                addrs[c][i] = LOG2_DEPTH'(random_bits(LOG2_DEPTH));
                write_word(c, MASK_MEM, addrs[c][i], random_bits(DATA_WIDTH));
            end
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int i = 0; i < WORDS_PER_CH; i++) begin
                read_word(c, RD_MEM, addrs[c][i], mem_model[addrs[c][i]]);
            end
        end
    endtask

    task automatic test_fifo_order();
        logic [DATA_WIDTH-1:0] exp;
        for (int i = 0; i < 6; i++) begin
            write_word(1, MASK_FIFO, '0, random_bits(DATA_WIDTH));
            if (i == 0 && empty !== 1'b0) report_error("empty high two cycles after a push");
        end
        while (fifo_model.size() > 0) begin
            exp = fifo_model.pop_front();
            read_word(0, RD_FIFO, '0, exp);
        end
        if (empty !== 1'b1) report_error("empty low after the last pop");
    endtask

    task automatic test_dual_write();
        logic [DATA_WIDTH-1:0] word;
        logic [LOG2_DEPTH-1:0] addr;
        word = random_bits(DATA_WIDTH);
        addr = LOG2_DEPTH'(random_bits(LOG2_DEPTH));
        write_word(0, MASK_BOTH, addr, word);
        if (count !== 1) report_error($sformatf("count %0d after a dual write", count));
        read_word(0, RD_MEM, addr, word);
        void'(fifo_model.pop_front());
        read_word(1, RD_FIFO, '0, word);
    endtask

    task automatic test_priority();
        logic [DATA_WIDTH-1:0] d0;
        write_word(0, MASK_MEM, 5'd3, random_bits(DATA_WIDTH));
        write_word(1, MASK_MEM, 5'd9, random_bits(DATA_WIDTH));
        ch_re           = '1;
        ch_rsel[0].code = RD_MEM;
        ch_rsel[1].code = RD_MEM;
        ch_raddr[0]     = 5'd3;
        ch_raddr[1]     = 5'd9;
        @(negedge clk);
        ch_re = '0;
        if (ch_rvalid !== NUM_CHANNELS'(1)) begin
            report_error($sformatf("rvalid %b on a read collision", ch_rvalid));
        end else if (ch_rdata[0] !== mem_model[3]) begin
            report_error($sformatf("ch 0 read %h, expected %h", ch_rdata[0], mem_model[3]));
        end
        @(negedge clk);
        // Same address from both channels in one cycle
        d0              = random_bits(DATA_WIDTH);
        ch_we           = '1;
        ch_wsel[0].mask = MASK_MEM;
        ch_wsel[1].mask = MASK_MEM;
        ch_waddr[0]     = 5'd12;
        ch_waddr[1]     = 5'd12;
        ch_wdata[0]     = d0;
        ch_wdata[1]     = random_bits(DATA_WIDTH);
        mem_model[12]   = d0;
        @(negedge clk);
        ch_we = '0;
        @(negedge clk);
        read_word(1, RD_MEM, 5'd12, d0);
    endtask

    task automatic test_fifo_limits();
        logic [DATA_WIDTH-1:0] exp;
        for (int i = 1; i <= DEPTH; i++) begin
            write_word(i % NUM_CHANNELS, MASK_FIFO, '0, random_bits(DATA_WIDTH));
            if (count !== i) report_error($sformatf("count %0d, expected %0d", count, i));
            if (almostfull !== (i >= DEPTH - AF_MARGIN)) begin
                report_error($sformatf("almostfull %b at count %0d", almostfull, i));
            end
        end
        write_word(0, MASK_FIFO, '0, random_bits(DATA_WIDTH));
        if (count !== DEPTH) report_error($sformatf("count %0d after push when full", count));
        for (int i = 0; i < DEPTH; i++) begin
            exp = fifo_model.pop_front();
            read_word(i % NUM_CHANNELS, RD_FIFO, '0, exp);
        end
        if (empty !== 1'b1 || count !== 0 || almostfull !== 1'b0) begin
            report_error("FIFO status wrong after draining");
        end
        ch_re[0]        = 1'b1;
        ch_rsel[0].code = RD_FIFO;
        @(negedge clk);
        ch_re[0] = 1'b0;
        if (ch_rvalid !== '0) report_error("rvalid on a pop from an empty FIFO");
        @(negedge clk);
    endtask

    initial begin
        rst      = 1'b1;
        ch_re    = '0;
        ch_rsel  = '0;
        ch_raddr = '0;
        ch_we    = '0;
        ch_wsel  = '0;
        ch_waddr = '0;
        ch_wdata = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        if (ch_rvalid !== '0 || empty !== 1'b1 || count !== 0 || almostfull !== 1'b0) begin
            report_error("outputs not in their reset state");
        end
        test_mem_rw();
        test_fifo_order();
        test_dual_write();
        test_priority();
        test_fifo_limits();
        $display("region_tb: 5 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
